// File: logic/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

	////////////////////////////////////////////////////////////
	// Instruction field widths
	////////////////////////////////////////////////////////////
	localparam int OpcodeWidth  = 6;
	localparam int FunctWidth   = 6;
	localparam int RegAddrWidth = 5;

	typedef logic [OpcodeWidth-1:0]  opcode_t;
	typedef logic [FunctWidth-1:0]   funct_t;
	typedef logic [RegAddrWidth-1:0] regAddr_t;

	////////////////////////////////////////////////////////////
	// Primary opcodes, instr[31:26]
	////////////////////////////////////////////////////////////
	localparam opcode_t OpRtype = 6'b000000; // SPECIAL, funct selects
	localparam opcode_t OpOri   = 6'b001101;
	localparam opcode_t OpLui   = 6'b001111;
	localparam opcode_t OpLw    = 6'b100011;
	localparam opcode_t OpSw    = 6'b101011;
	localparam opcode_t OpBeq   = 6'b000100;
	localparam opcode_t OpJ     = 6'b000010;

	// Funct codes under SPECIAL, instr[5:0]
	localparam funct_t FnAddu  = 6'b100001;
	localparam funct_t FnSubu  = 6'b100011;
	localparam funct_t FnAnd   = 6'b100100;
	localparam funct_t FnOr    = 6'b100101;
	localparam funct_t FnSlt   = 6'b101010;
	localparam funct_t FnMultu = 6'b011001;
	localparam funct_t FnMfhi  = 6'b010000;
	localparam funct_t FnMflo  = 6'b010010;

endpackage

`default_nettype wire

// File: logic/coreTypesPkg.sv
`default_nettype none

package coreTypesPkg;

	localparam int DataWidth = 32;
	typedef logic [DataWidth-1:0] word_t;

	localparam int MulSteps = 32; // One step per multiplier bit
	typedef logic [5:0] stepCount_t;

	typedef enum logic [2:0] {
		StFetch,
		StDecode,
		StExecute,
		StMulWait,
		StMemory,
		StWriteback
	} coreState_t;

	typedef enum logic [2:0] {AluAdd, AluSub, AluAnd, AluOr, AluSlt, AluLui} aluOp_t;

	// Source of the register write value
	typedef enum logic [1:0] {WbAlu, WbMem, WbHi, WbLo} wbSel_t;

endpackage

`default_nettype wire

// File: logic/mduTimer.sv
`timescale 1ns/1ps
`default_nettype none

module mduTimer (
	input  wire  clk,
	input  wire  reset,
	input  wire  mulStart,
	output logic mulDone
);
	import coreTypesPkg::*;

	stepCount_t stepsLeft;

	always_ff @(posedge clk) begin
		if (reset) begin
			stepsLeft <= '0;
		end else if (mulStart) begin
			stepsLeft <= stepCount_t'(MulSteps);
		end else if (stepsLeft != '0) begin
			stepsLeft <= stepsLeft - stepCount_t'(1);
		end
	end

	// High during the last step, so the wait lasts MulSteps cycles
	assign mulDone = (stepsLeft == stepCount_t'(1));
endmodule

`default_nettype wire

// File: logic/pcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module pcUnit #(
	parameter coreTypesPkg::word_t ResetPc = 32'h0000_3000
) (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       pcWrite,
	input  wire                       irWrite,
	input  wire                       branchTaken,
	input  wire                       jumpTaken,
	input  wire coreTypesPkg::word_t  iInstRdata,
	output coreTypesPkg::word_t       pc,
	output coreTypesPkg::word_t       instr,
	output coreTypesPkg::word_t       instrPc  // Address the held instruction came from
);
	import coreTypesPkg::*;

	word_t branchTarget;
	word_t jumpTarget;
	word_t nextPc;

	// After fetch pc already holds PC + 4
	assign branchTarget = pc + {{14{instr[15]}}, instr[15:0], 2'b00};
	assign jumpTarget   = {pc[31:28], instr[25:0], 2'b00};
	assign nextPc       = jumpTaken ? jumpTarget : branchTaken ? branchTarget : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= ResetPc;
		end else if (pcWrite) begin
			pc <= nextPc;
		end
	end

	always_ff @(posedge clk) begin
		if (irWrite) begin
			instr   <= iInstRdata;
			instrPc <= pc;
		end
	end
endmodule

`default_nettype wire

// File: logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input  wire                        clk,
	input  wire                        reset,
	input  wire coreTypesPkg::word_t   instr,
	input  wire                        regWrite,
	input  wire mipsIsaPkg::regAddr_t  regWriteAddr,
	input  wire coreTypesPkg::word_t   writeData,
	output coreTypesPkg::word_t        rsData,
	output coreTypesPkg::word_t        rtData
);
	import coreTypesPkg::*;
	import mipsIsaPkg::*;

	word_t    regs [2**RegAddrWidth];
	regAddr_t rsAddr;
	regAddr_t rtAddr;

	assign rsAddr = instr[25:21];
	assign rtAddr = instr[20:16];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2**RegAddrWidth; i++) begin
				regs[i] <= '0;
			end
		end else if (regWrite && regWriteAddr != '0) begin // $0 stays zero
			regs[regWriteAddr] <= writeData;
		end
	end

	// Asynchronous read, stable for the whole instruction
	assign rsData = regs[rsAddr];
	assign rtData = regs[rtAddr];
endmodule

`default_nettype wire

// File: logic/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit (
	input  wire coreTypesPkg::word_t   rsData,
	input  wire coreTypesPkg::word_t   rtData,
	input  wire coreTypesPkg::word_t   instr,
	input  wire coreTypesPkg::aluOp_t  aluOp,
	input  wire                        useImm,
	input  wire                        zeroExt,
	input  wire coreTypesPkg::word_t   mDataRdata,
	input  wire coreTypesPkg::word_t   hi,
	input  wire coreTypesPkg::word_t   lo,
	input  wire coreTypesPkg::wbSel_t  wbSel,
	output coreTypesPkg::word_t        aluResult,
	output logic                       aluZero,
	output coreTypesPkg::word_t        writeData
);
	import coreTypesPkg::*;

	word_t immExt;
	word_t srcB;

	assign immExt = zeroExt ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
	assign srcB   = useImm ? immExt : rtData;

	always_comb begin
		case (aluOp)
			AluAdd:  aluResult = rsData + srcB;
			AluSub:  aluResult = rsData - srcB;
			AluAnd:  aluResult = rsData & srcB;
			AluOr:   aluResult = rsData | srcB;
			AluSlt:  aluResult = word_t'($signed(rsData) < $signed(srcB));
			AluLui:  aluResult = {instr[15:0], 16'h0000};
			default: aluResult = rsData + srcB;
		endcase
	end

	assign aluZero = (aluResult == '0); // beq runs a subtract

	// Write-back source
	always_comb begin
		case (wbSel)
			WbMem:   writeData = mDataRdata;
			WbHi:    writeData = hi;
			WbLo:    writeData = lo;
			default: writeData = aluResult;
		endcase
	end
endmodule

`default_nettype wire

// File: logic/mulDivUnit.sv
`timescale 1ns/1ps
`default_nettype none

module mulDivUnit (
	input  wire                       clk,
	input  wire                       reset,
	input  wire coreTypesPkg::word_t  rsData,
	input  wire coreTypesPkg::word_t  rtData,
	input  wire                       mulStart,
	input  wire                       mulStep,
	output coreTypesPkg::word_t       hi,
	output coreTypesPkg::word_t       lo
);
	import coreTypesPkg::*;

	word_t              multiplicand;
	logic [DataWidth:0] partialSum;

	// Add into the upper half and keep the carry for the shift
	assign partialSum = {1'b0, hi} + (lo[0] ? {1'b0, multiplicand} : '0);

	always_ff @(posedge clk) begin
		if (mulStart) begin
			multiplicand <= rsData;
		end
	end

	////////////////////////////////////////////////////////////
	// HI/LO double as the product register
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			hi <= '0;
			lo <= '0;
		end else if (mulStart) begin
			hi <= '0;
			lo <= rtData; // Multiplier leaves LO as product bits come in
		end else if (mulStep) begin
			hi <= partialSum[DataWidth:1];
			lo <= {partialSum[0], lo[DataWidth-1:1]};
		end
	end
endmodule

`default_nettype wire

// File: logic/coreControl.sv
`timescale 1ns/1ps
`default_nettype none

module coreControl (
	input  wire                       clk,
	input  wire                       reset,
	input  wire coreTypesPkg::word_t  instr,
	input  wire                       aluZero,
	input  wire                       mulDone,
	output logic                      pcWrite,
	output logic                      irWrite,
	output logic                      branchTaken,
	output logic                      jumpTaken,
	output logic                      regWrite,
	output mipsIsaPkg::regAddr_t      regWriteAddr,
	output coreTypesPkg::wbSel_t      wbSel,
	output coreTypesPkg::aluOp_t      aluOp,
	output logic                      useImm,
	output logic                      zeroExt,
	output logic                      mulStart,
	output logic                      mulStep,
	output logic                      memWrite
);
	import coreTypesPkg::*;
	import mipsIsaPkg::*;

	opcode_t    opcode;
	funct_t     funct;
	logic       isRtype;
	logic       isAluR;
	logic       isMultu;
	logic       isMfhi;
	logic       isMflo;
	logic       isWriteback;
	coreState_t state;
	coreState_t nextState;

	////////////////////////////////////////////////////////////
	// Decode of the held instruction
	////////////////////////////////////////////////////////////
	assign opcode  = instr[31:26];
	assign funct   = instr[5:0];
	assign isRtype = (opcode == OpRtype);
	assign isAluR  = isRtype && (funct == FnAddu || funct == FnSubu || funct == FnAnd ||
		funct == FnOr || funct == FnSlt);
	assign isMultu = isRtype && (funct == FnMultu);
	assign isMfhi  = isRtype && (funct == FnMfhi);
	assign isMflo  = isRtype && (funct == FnMflo);

	// Everything that ends in a register write
	assign isWriteback = isAluR || isMfhi || isMflo || opcode == OpOri || opcode == OpLui;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= StFetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = StFetch;
		case (state)
			StFetch:  nextState = StDecode;
			StDecode: nextState = StExecute;
			StExecute: begin
				if (isMultu) begin
					nextState = StMulWait;
				end else if (opcode == OpLw || opcode == OpSw) begin
					nextState = StMemory;
				end else if (isWriteback) begin
					nextState = StWriteback;
				end // beq, j and unknown codes go back to fetch
			end
			StMulWait:   nextState = mulDone ? StFetch : StMulWait;
			StMemory:    nextState = (opcode == OpLw) ? StWriteback : StFetch;
			StWriteback: nextState = StFetch;
			default:     nextState = StFetch;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Steering
	////////////////////////////////////////////////////////////
	assign irWrite     = (state == StFetch);
	assign branchTaken = (state == StExecute) && opcode == OpBeq && aluZero;
	assign jumpTaken   = (state == StExecute) && opcode == OpJ;
	assign pcWrite     = irWrite || branchTaken || jumpTaken; // PC + 4 in fetch

	assign regWrite     = (state == StWriteback);
	assign regWriteAddr = isRtype ? instr[15:11] : instr[20:16]; // rd or rt
	assign memWrite     = (state == StMemory) && opcode == OpSw;
	assign mulStart     = (state == StExecute) && isMultu;
	assign mulStep      = (state == StMulWait);

	assign useImm  = (opcode == OpOri || opcode == OpLui || opcode == OpLw || opcode == OpSw);
	assign zeroExt = (opcode == OpOri);

	always_comb begin
		aluOp = AluAdd; // lw, sw and addu
		if (isRtype) begin
			case (funct)
				FnSubu:  aluOp = AluSub;
				FnAnd:   aluOp = AluAnd;
				FnOr:    aluOp = AluOr;
				FnSlt:   aluOp = AluSlt;
				default: aluOp = AluAdd;
			endcase
		end else if (opcode == OpOri) begin
			aluOp = AluOr;
		end else if (opcode == OpLui) begin
			aluOp = AluLui;
		end else if (opcode == OpBeq) begin
			aluOp = AluSub; // Equal when the difference is zero
		end
	end

	assign wbSel = (opcode == OpLw) ? WbMem : isMfhi ? WbHi : isMflo ? WbLo : WbAlu;
endmodule

`default_nettype wire

// File: logic/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore #(
	parameter coreTypesPkg::word_t ResetPc = 32'h0000_3000
) (
	input  wire                       clk,
	input  wire                       reset,
	input  wire coreTypesPkg::word_t  iInstRdata,  // Instruction word at iInstAddr
	input  wire coreTypesPkg::word_t  mDataRdata,  // Load data at mDataAddr
	output coreTypesPkg::word_t       iInstAddr,
	output coreTypesPkg::word_t       mDataAddr,
	output coreTypesPkg::word_t       mDataWdata,
	output logic [3:0]                mDataByteen,
	output logic                      wGrfWe,      // Register write trace
	output mipsIsaPkg::regAddr_t      wGrfAddr,
	output coreTypesPkg::word_t       wGrfWdata,
	output coreTypesPkg::word_t       wInstAddr    // PC of the retiring instruction
);
	import coreTypesPkg::*;
	import mipsIsaPkg::*;

	// Control to datapath
	logic     pcWrite;
	logic     irWrite;
	logic     branchTaken;
	logic     jumpTaken;
	logic     regWrite;
	regAddr_t regWriteAddr;
	wbSel_t   wbSel;
	aluOp_t   aluOp;
	logic     useImm;
	logic     zeroExt;
	logic     mulStart;
	logic     mulStep;
	logic     mulDone;
	logic     memWrite;

	// Datapath
	word_t pc;
	word_t instr;
	word_t instrPc;
	word_t rsData;
	word_t rtData;
	word_t aluResult;
	logic  aluZero;
	word_t writeData;
	word_t hi;
	word_t lo;

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////
	coreControl control (
		.clk, .reset, .instr, .aluZero, .mulDone,
		.pcWrite, .irWrite, .branchTaken, .jumpTaken,
		.regWrite, .regWriteAddr, .wbSel,
		.aluOp, .useImm, .zeroExt,
		.mulStart, .mulStep, .memWrite
	);

	mduTimer timer (.clk, .reset, .mulStart, .mulDone);

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////
	pcUnit #(.ResetPc(ResetPc)) fetch (
		.clk, .reset, .pcWrite, .irWrite, .branchTaken, .jumpTaken,
		.iInstRdata, .pc, .instr, .instrPc
	);

	regFile grf (
		.clk, .reset, .instr, .regWrite, .regWriteAddr, .writeData,
		.rsData, .rtData
	);

	execUnit exec (
		.rsData, .rtData, .instr, .aluOp, .useImm, .zeroExt,
		.mDataRdata, .hi, .lo, .wbSel,
		.aluResult, .aluZero, .writeData
	);

	mulDivUnit mdu (.clk, .reset, .rsData, .rtData, .mulStart, .mulStep, .hi, .lo);

	////////////////////////////////////////////////////////////
	// External ports
	////////////////////////////////////////////////////////////
	assign iInstAddr   = pc;
	assign mDataAddr   = aluResult;    // rs + offset for lw and sw
	assign mDataWdata  = rtData;
	assign mDataByteen = {4{memWrite}}; // Whole words only

	assign wGrfWe    = regWrite;
	assign wGrfAddr  = regWriteAddr;
	assign wGrfWdata = writeData;
	assign wInstAddr = instrPc;
endmodule

`default_nettype wire

// File: include/programTable.svh
`ifndef PROGRAM_TABLE_SVH
`define PROGRAM_TABLE_SVH

// Program at ResetPc, one word per ROM entry
localparam int ProgLen = 28;
localparam logic [31:0] ProgWords [ProgLen] = '{
	32'h3401_0005, 32'h3402_0003, 32'h0022_1821, 32'h0022_2023, // ori ori addu subu
	32'h0022_2824, 32'h0022_3025, 32'h0041_382a, 32'h3c08_1234, // and or slt lui
	32'h3400_00ff, 32'h0001_4821, 32'hac03_0010, 32'h8c0a_0010, // ori $0, addu, sw, lw
	32'h1022_0005, 32'h1029_0002, 32'h340b_0001, 32'h340b_0002, // beq untaken, beq taken
	32'h0800_0c13, 32'h340c_0003, 32'h340c_0004, 32'h340d_0bad, // j over two words
	32'h3c0e_0000, 32'h35ce_0000, 32'h3c0f_0000, 32'h35ef_0000, // operand loads
	32'h01cf_0019, 32'h0000_8010, 32'h0000_8812, 32'h0800_0c1b  // multu mfhi mflo, spin
};

// Immediates of these lui/ori pairs take the random operand halves
localparam int ProgIdxOpA = 20;
localparam int ProgIdxOpB = 22;

typedef struct packed {
	logic [31:0] pc;
	logic [4:0]  regNum;
	logic [31:0] value;
} expWrite_t;

localparam int NumExp = 18;
localparam expWrite_t ExpTable [NumExp] = '{
	'{32'h3000, 5'd1, 32'h5},        '{32'h3004, 5'd2, 32'h3},
	'{32'h3008, 5'd3, 32'h8},        '{32'h300c, 5'd4, 32'h2},
	'{32'h3010, 5'd5, 32'h1},        '{32'h3014, 5'd6, 32'h7},
	'{32'h3018, 5'd7, 32'h1},        '{32'h301c, 5'd8, 32'h1234_0000},
	'{32'h3020, 5'd0, 32'hff},       '{32'h3024, 5'd9, 32'h5},
	'{32'h302c, 5'd10, 32'h8},       '{32'h304c, 5'd13, 32'hbad},
	'{32'h3050, 5'd14, 32'h0},       '{32'h3054, 5'd14, 32'h0},
	'{32'h3058, 5'd15, 32'h0},       '{32'h305c, 5'd15, 32'h0},
	'{32'h3064, 5'd16, 32'h0},       '{32'h3068, 5'd17, 32'h0}
};

// Rows left at zero, filled from the operands and their product
localparam int ExpIdxOpA = 12; // lui row, ori row follows
localparam int ExpIdxOpB = 14;
localparam int ExpIdxHi  = 16;
localparam int ExpIdxLo  = 17;

`endif

// File: verification/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;
	import coreTypesPkg::*;
	import mipsIsaPkg::*;

	`include "programTable.svh"

	localparam word_t ResetPc       = 32'h0000_3000;
	localparam int    RomWords      = 64;
	localparam int    RamWords      = 64;
	localparam int    ResetCycles   = 5;
	localparam int    MaxWaitCycles = 100;           // multu alone needs MulSteps + 3
	localparam word_t StoreAddr     = 32'h0000_0010; // sw $3, 16($0)
	localparam int    StoreSrcRow   = 2;             // Row that wrote $3

	logic        clk;
	logic        reset;
	word_t       iInstRdata;
	word_t       mDataRdata;
	word_t       iInstAddr;
	word_t       mDataAddr;
	word_t       mDataWdata;
	logic [3:0]  mDataByteen;
	logic        wGrfWe;
	regAddr_t    wGrfAddr;
	word_t       wGrfWdata;
	word_t       wInstAddr;

	integer      seed;
	word_t       opA;
	word_t       opB;
	logic [63:0] product;
	word_t       rom [RomWords];
	word_t       ram [RamWords];
	word_t       romIndex;
	expWrite_t   expRows [NumExp];
	int          writesSeen;
	int          storesSeen;

	mipsCore #(.ResetPc(ResetPc)) UUT (
		.clk, .reset, .iInstRdata, .mDataRdata,
		.iInstAddr, .mDataAddr, .mDataWdata, .mDataByteen,
		.wGrfWe, .wGrfAddr, .wGrfWdata, .wInstAddr
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Memory models
	////////////////////////////////////////////////////////////
	assign romIndex   = (iInstAddr - ResetPc) >> 2;
	assign iInstRdata = (romIndex < RomWords) ? rom[romIndex[5:0]] : '0; // Outside ROM reads 0
	assign mDataRdata = ram[mDataAddr[7:2]];

	always @(posedge clk) begin
		if (mDataByteen == 4'b1111) begin
			ram[mDataAddr[7:2]] <= mDataWdata;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////
	task automatic reportFailure(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic checkValue(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			reportFailure($sformatf("FAIL at %0t ns: %s is %h, expected %h",
				$time, name, actual, expected));
		end
	endtask

	// Waits at each falling edge for the next register write
	task automatic waitForWrite(input int row);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!wGrfWe && cycles < MaxWaitCycles);
		if (!wGrfWe) begin
			reportFailure($sformatf("Timeout: register write %0d from PC %h never arrived",
				row, expRows[row].pc));
		end
	endtask

	// Only one store in the program
	always @(negedge clk) begin
		if (!reset && mDataByteen != 4'b0000) begin
			if (writesSeen == 0) begin
				reportFailure("mDataByteen rose before the first register write");
			end else if (storesSeen != 0) begin
				reportFailure("A second store appeared, the program holds a single sw");
			end
			checkValue("mDataByteen", word_t'(mDataByteen), 32'h0000_000f);
			checkValue("mDataAddr", mDataAddr, StoreAddr);
			checkValue("mDataWdata", mDataWdata, expRows[StoreSrcRow].value);
			storesSeen++;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus and table walk
	////////////////////////////////////////////////////////////
	initial begin
		reset      = 1'b1;
		writesSeen = 0;
		storesSeen = 0;
		seed       = 32'hdbc6;
		opA        = $random(seed);
		opB        = $random(seed);
		product    = {32'h0, opA} * {32'h0, opB}; // Unsigned 64-bit product

		for (int i = 0; i < RomWords; i++) begin
			rom[i] = (i < ProgLen) ? ProgWords[i] : '0;
		end
		// lui takes the upper half, ori the lower
		rom[ProgIdxOpA]     = {ProgWords[ProgIdxOpA][31:16], opA[31:16]};
		rom[ProgIdxOpA + 1] = {ProgWords[ProgIdxOpA + 1][31:16], opA[15:0]};
		rom[ProgIdxOpB]     = {ProgWords[ProgIdxOpB][31:16], opB[31:16]};
		rom[ProgIdxOpB + 1] = {ProgWords[ProgIdxOpB + 1][31:16], opB[15:0]};

		for (int i = 0; i < NumExp; i++) begin
			expRows[i] = ExpTable[i];
		end
		expRows[ExpIdxOpA].value     = {opA[31:16], 16'h0000};
		expRows[ExpIdxOpA + 1].value = opA;
		expRows[ExpIdxOpB].value     = {opB[31:16], 16'h0000};
		expRows[ExpIdxOpB + 1].value = opB;
		expRows[ExpIdxHi].value      = product[63:32];
		expRows[ExpIdxLo].value      = product[31:0];

		for (int i = 0; i < RamWords; i++) begin
			ram[i] = 32'h5a5a_0000 ^ word_t'(i * 4); // Address-dependent fill
		end

		for (int c = 0; c < ResetCycles; c++) begin
			@(negedge clk);
			checkValue("wGrfWe", word_t'(wGrfWe), 32'd0);
			checkValue("mDataByteen", word_t'(mDataByteen), 32'd0);
		end
		checkValue("iInstAddr", iInstAddr, ResetPc); // First fetch
		reset = 1'b0;

		for (int row = 0; row < NumExp; row++) begin
			waitForWrite(row);
			checkValue("wInstAddr", wInstAddr, expRows[row].pc);
			checkValue("wGrfAddr", word_t'(wGrfAddr), word_t'(expRows[row].regNum));
			checkValue("wGrfWdata", wGrfWdata, expRows[row].value);
			writesSeen++;
		end
		checkValue("storesSeen", word_t'(storesSeen), 32'd1);

		$display("ALL CHECKS PASSED");
		$finish;
	end
endmodule

`default_nettype wire

// File: list.f
+incdir+include
logic/mipsIsaPkg.sv
logic/coreTypesPkg.sv
logic/mduTimer.sv
logic/pcUnit.sv
logic/regFile.sv
logic/execUnit.sv
logic/mulDivUnit.sv
logic/coreControl.sv
logic/mipsCore.sv
verification/mipsCoreTb.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - files:
      - logic/mipsIsaPkg.sv
      - logic/coreTypesPkg.sv
      - logic/mduTimer.sv
      - logic/pcUnit.sv
      - logic/regFile.sv
      - logic/execUnit.sv
      - logic/mulDivUnit.sv
      - logic/coreControl.sv
      - logic/mipsCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/mipsCoreTb.sv
